/* files.f */
+incdir+rtl
rtl/csr_pkg.sv
rtl/trap_pkg.sv
rtl/csr_control.sv
rtl/csr_regfile.sv
rtl/trap_ctrl.sv
rtl/csr_unit.sv
sim/csr_checker.sv
sim/csr_unit_tb.sv

/* rtl/csr_consts.svh */
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// widths
`define DATA_WIDTH      32
`define CSR_ADDR_WIDTH  12
`define FUNC3_WIDTH     3

// machine CSR addresses
`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

// system instructions, funct3 == 0, selected by the immediate field
`define SYS_ECALL       12'h000
`define SYS_EBREAK      12'h001
`define SYS_MRET_ALT0   12'h002
`define SYS_MRET_ALT1   12'h102
`define SYS_MRET        12'h302
`define SYS_WFI         12'h105

// funct3 codes
`define F3_PRIV         3'b000
`define F3_CSRRW        3'b001
`define F3_CSRRS        3'b010
`define F3_CSRRC        3'b011
`define F3_CSRRWI       3'b101
`define F3_CSRRSI       3'b110
`define F3_CSRRCI       3'b111

// status bit positions
`define MSTATUS_MIE     3
`define MSTATUS_MPIE    7
`define MIE_MEIE        11

// mcause values
`define CAUSE_ECALL_M     32'd11
`define CAUSE_BREAKPOINT  32'd3
`define CAUSE_M_EXT_IRQ   32'h8000_000b

`endif

/* rtl/csr_control.sv */
`timescale 1ns/100ps

`include "csr_consts.svh"

module csr_control (
	input  logic               valid_i,
	input  csr_pkg::funct3_t   funct3_i,
	input  csr_pkg::csr_addr_t csr_addr_i,
	input  csr_pkg::xlen_t     rs1_data_i,
	input  csr_pkg::xlen_t     imm_i,
	input  csr_pkg::xlen_t     rdata_i,
	output logic               csr_we_o,
	output csr_pkg::xlen_t     wdata_o,
	output logic               is_ecall_o,
	output logic               is_ebreak_o,
	output logic               is_mret_o,
	output logic               is_wfi_o
);

	import csr_pkg::*;

	xlen_t operand;
	logic  is_priv;

	// immediate forms have funct3[2] set
	assign operand = funct3_i[2] ? imm_i : rs1_data_i;
	assign is_priv = valid_i && (funct3_i == `F3_PRIV);

	always_comb begin
		wdata_o  = rdata_i;
		csr_we_o = 1'b0;
		case (funct3_i)
			`F3_CSRRW, `F3_CSRRWI: begin
				wdata_o  = operand;
				csr_we_o = valid_i;
			end
			`F3_CSRRS, `F3_CSRRSI: begin
				wdata_o  = rdata_i | operand;
				csr_we_o = valid_i;
			end
			`F3_CSRRC, `F3_CSRRCI: begin
				wdata_o  = rdata_i & ~operand;
				csr_we_o = valid_i;
			end
			default: begin
				wdata_o  = rdata_i;
				csr_we_o = 1'b0;
			end
		endcase
	end

	// privileged forms select one flag by address
	always_comb begin
		is_ecall_o  = 1'b0;
		is_ebreak_o = 1'b0;
		is_mret_o   = 1'b0;
		is_wfi_o    = 1'b0;
		if (is_priv) begin
			case (csr_addr_i)
				`SYS_ECALL: begin
					is_ecall_o = 1'b1;
				end
				`SYS_EBREAK: begin
					is_ebreak_o = 1'b1;
				end
				`SYS_MRET, `SYS_MRET_ALT0, `SYS_MRET_ALT1: begin
					is_mret_o = 1'b1;
				end
				`SYS_WFI: begin
					is_wfi_o = 1'b1;
				end
				default: begin
					is_ecall_o = 1'b0;
				end
			endcase
		end
	end

	// the trap block relies on exclusive flags
	always_comb begin
		assert #0 ($onehot0({is_ecall_o, is_ebreak_o, is_mret_o, is_wfi_o, csr_we_o}))
		else $error("csr_control: system flags not exclusive with write enable");
	end

endmodule

/* rtl/csr_pkg.sv */
`include "csr_consts.svh"

package csr_pkg;

	// register and data word
	typedef logic [`DATA_WIDTH-1:0] xlen_t;

	// 12-bit CSR address field
	typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;

	// operation field of a SYSTEM instruction
	typedef logic [`FUNC3_WIDTH-1:0] funct3_t;

endpackage

/* rtl/csr_regfile.sv */
`timescale 1ns/100ps

`include "csr_consts.svh"

module csr_regfile (
	input  logic               clk,
	input  logic               reset_i,
	input  csr_pkg::csr_addr_t csr_addr_i,
	input  logic               csr_we_i,
	input  csr_pkg::xlen_t     wdata_i,
	input  logic               trap_we_i,
	input  csr_pkg::xlen_t     trap_mepc_i,
	input  trap_pkg::cause_t   trap_mcause_i,
	input  logic               mret_we_i,
	output csr_pkg::xlen_t     rdata_o,
	output csr_pkg::xlen_t     mtvec_o,
	output csr_pkg::xlen_t     mepc_o,
	output logic               mstatus_mie_o,
	output logic               mie_meie_o
);

	import csr_pkg::*;
	import trap_pkg::*;

	// only the implemented fields are stored
	logic   mstatus_mie;
	logic   mstatus_mpie;
	logic   mie_meie;
	xlen_t  mtvec;
	xlen_t  mscratch;
	xlen_t  mepc;
	cause_t mcause;

	xlen_t mstatus_val;
	xlen_t mie_val;

	always_comb begin
		mstatus_val = '0;
		mstatus_val[`MSTATUS_MIE]  = mstatus_mie;
		mstatus_val[`MSTATUS_MPIE] = mstatus_mpie;
		mie_val = '0;
		mie_val[`MIE_MEIE] = mie_meie;
	end

	always_comb begin
		case (csr_addr_i)
			`CSR_MSTATUS:  rdata_o = mstatus_val;
			`CSR_MIE:      rdata_o = mie_val;
			`CSR_MTVEC:    rdata_o = mtvec;
			`CSR_MSCRATCH: rdata_o = mscratch;
			`CSR_MEPC:     rdata_o = mepc;
			`CSR_MCAUSE:   rdata_o = mcause;
			default:       rdata_o = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_meie     <= 1'b0;
			mtvec        <= '0;
			mscratch     <= '0;
			mepc         <= '0;
			mcause       <= '0;
		end else if (trap_we_i) begin
			// trap entry stacks the interrupt enable
			mstatus_mpie <= mstatus_mie;
			mstatus_mie  <= 1'b0;
			mepc         <= {trap_mepc_i[`DATA_WIDTH-1:2], 2'b00};
			mcause       <= trap_mcause_i;
		end else if (mret_we_i) begin
			mstatus_mie  <= mstatus_mpie;
			mstatus_mpie <= 1'b1;
		end else if (csr_we_i) begin
			case (csr_addr_i)
				`CSR_MSTATUS: begin
					mstatus_mie  <= wdata_i[`MSTATUS_MIE];
					mstatus_mpie <= wdata_i[`MSTATUS_MPIE];
				end
				`CSR_MIE: begin
					mie_meie <= wdata_i[`MIE_MEIE];
				end
				`CSR_MTVEC: begin
					// direct mode only
					mtvec <= {wdata_i[`DATA_WIDTH-1:2], 2'b00};
				end
				`CSR_MSCRATCH: begin
					mscratch <= wdata_i;
				end
				`CSR_MEPC: begin
					mepc <= {wdata_i[`DATA_WIDTH-1:2], 2'b00};
				end
				`CSR_MCAUSE: begin
					mcause <= wdata_i;
				end
				default: begin
					mscratch <= mscratch;
				end
			endcase
		end
	end

	assign mtvec_o       = mtvec;
	assign mepc_o        = mepc;
	assign mstatus_mie_o = mstatus_mie;
	assign mie_meie_o    = mie_meie;

	// decode and trap control must never claim the same edge
	a_no_write_clash: assert property (
		@(posedge clk) disable iff (reset_i)
		!(trap_we_i && (csr_we_i || mret_we_i))
	) else $error("csr_regfile: trap write collides with instruction write");

endmodule

/* rtl/csr_unit.sv */
`timescale 1ns/100ps

module csr_unit (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               valid_i,
	input  csr_pkg::funct3_t   funct3_i,
	input  csr_pkg::csr_addr_t csr_addr_i,
	input  csr_pkg::xlen_t     rs1_data_i,
	input  csr_pkg::xlen_t     imm_i,
	input  csr_pkg::xlen_t     pc_i,
	input  logic               irq_i,
	output csr_pkg::xlen_t     rd_data_o,
	output logic               redirect_o,
	output csr_pkg::xlen_t     redirect_pc_o,
	output logic               stall_o
);

	import csr_pkg::*;
	import trap_pkg::*;

	logic   exec_valid;
	logic   csr_we;
	xlen_t  wdata;
	logic   is_ecall;
	logic   is_ebreak;
	logic   is_mret;
	logic   is_wfi;
	logic   trap_we;
	xlen_t  trap_mepc;
	cause_t trap_mcause;
	logic   mret_we;
	xlen_t  mtvec;
	xlen_t  mepc;
	logic   mstatus_mie;
	logic   mie_meie;

	// held instruction does not execute while asleep
	assign exec_valid = valid_i && !stall_o;

	// old value goes out as rd and back into the decode
	csr_control u_csr_control (
		.valid_i     (exec_valid),
		.funct3_i    (funct3_i),
		.csr_addr_i  (csr_addr_i),
		.rs1_data_i  (rs1_data_i),
		.imm_i       (imm_i),
		.rdata_i     (rd_data_o),
		.csr_we_o    (csr_we),
		.wdata_o     (wdata),
		.is_ecall_o  (is_ecall),
		.is_ebreak_o (is_ebreak),
		.is_mret_o   (is_mret),
		.is_wfi_o    (is_wfi)
	);

	csr_regfile u_csr_regfile (
		.clk           (clk),
		.reset_i       (reset_i),
		.csr_addr_i    (csr_addr_i),
		.csr_we_i      (csr_we),
		.wdata_i       (wdata),
		.trap_we_i     (trap_we),
		.trap_mepc_i   (trap_mepc),
		.trap_mcause_i (trap_mcause),
		.mret_we_i     (mret_we),
		.rdata_o       (rd_data_o),
		.mtvec_o       (mtvec),
		.mepc_o        (mepc),
		.mstatus_mie_o (mstatus_mie),
		.mie_meie_o    (mie_meie)
	);

	trap_ctrl u_trap_ctrl (
		.clk           (clk),
		.reset_i       (reset_i),
		.valid_i       (valid_i),
		.pc_i          (pc_i),
		.irq_i         (irq_i),
		.is_ecall_i    (is_ecall),
		.is_ebreak_i   (is_ebreak),
		.is_mret_i     (is_mret),
		.is_wfi_i      (is_wfi),
		.mtvec_i       (mtvec),
		.mepc_i        (mepc),
		.mstatus_mie_i (mstatus_mie),
		.mie_meie_i    (mie_meie),
		.trap_we_o     (trap_we),
		.trap_mepc_o   (trap_mepc),
		.trap_mcause_o (trap_mcause),
		.mret_we_o     (mret_we),
		.redirect_o    (redirect_o),
		.redirect_pc_o (redirect_pc_o),
		.stall_o       (stall_o)
	);

endmodule

/* rtl/trap_ctrl.sv */
`timescale 1ns/100ps

`include "csr_consts.svh"

module trap_ctrl (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             valid_i,
	input  csr_pkg::xlen_t   pc_i,
	input  logic             irq_i,
	input  logic             is_ecall_i,
	input  logic             is_ebreak_i,
	input  logic             is_mret_i,
	input  logic             is_wfi_i,
	input  csr_pkg::xlen_t   mtvec_i,
	input  csr_pkg::xlen_t   mepc_i,
	input  logic             mstatus_mie_i,
	input  logic             mie_meie_i,
	output logic             trap_we_o,
	output csr_pkg::xlen_t   trap_mepc_o,
	output trap_pkg::cause_t trap_mcause_o,
	output logic             mret_we_o,
	output logic             redirect_o,
	output csr_pkg::xlen_t   redirect_pc_o,
	output logic             stall_o
);

	import csr_pkg::*;
	import trap_pkg::*;

	wfi_state_t state;
	logic       sleeping;
	logic       accept;
	logic       take_ecall;
	logic       take_ebreak;
	logic       take_mret;
	logic       take_wfi;
	logic       take_irq;
	logic       take_any;
	xlen_t      target;

	assign sleeping = (state == WFI_SLEEP);

	// held instruction is ignored while asleep
	// and the slot after a redirect is wrong-path
	assign accept = !sleeping && !redirect_o;

	assign take_ecall  = accept && is_ecall_i;
	assign take_ebreak = accept && is_ebreak_i;
	assign take_mret   = accept && is_mret_i;
	assign take_wfi    = accept && is_wfi_i;
	assign take_irq    = accept && !valid_i && irq_i && mstatus_mie_i && mie_meie_i;
	assign take_any    = take_ecall || take_ebreak || take_mret || take_irq;

	assign trap_we_o   = take_ecall || take_ebreak || take_irq;
	assign trap_mepc_o = pc_i;
	assign mret_we_o   = take_mret;

	always_comb begin
		if (take_ecall) begin
			trap_mcause_o = `CAUSE_ECALL_M;
		end else if (take_ebreak) begin
			trap_mcause_o = `CAUSE_BREAKPOINT;
		end else begin
			trap_mcause_o = `CAUSE_M_EXT_IRQ;
		end
	end

	assign target = take_mret ? mepc_i : mtvec_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			redirect_o <= 1'b0;
		end else begin
			redirect_o <= take_any;
		end
	end

	always_ff @(posedge clk) begin
		if (take_any) begin
			redirect_pc_o <= target;
		end
	end

	// wake on any irq level, enabled or not
	always_ff @(posedge clk) begin
		if (reset_i) begin
			state <= WFI_RUN;
		end else begin
			case (state)
				WFI_RUN: begin
					if (take_wfi) begin
						state <= WFI_SLEEP;
					end
				end
				WFI_SLEEP: begin
					if (irq_i) begin
						state <= WFI_RUN;
					end
				end
				default: begin
					state <= WFI_RUN;
				end
			endcase
		end
	end

	assign stall_o = sleeping;

	a_redirect_pulse: assert property (
		@(posedge clk) disable iff (reset_i)
		redirect_o |=> !redirect_o
	) else $error("trap_ctrl: redirect held for two cycles");

endmodule

/* rtl/trap_pkg.sv */
`include "csr_consts.svh"

package trap_pkg;

	// mcause value, bit 31 marks an interrupt
	typedef logic [`DATA_WIDTH-1:0] cause_t;

	// sleep state after wfi
	typedef enum logic {
		WFI_RUN,
		WFI_SLEEP
	} wfi_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build the csr_unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module csr_unit_tb \
	-o csr_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/csr_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
	exit 0
else
	exit 1
fi

/* sim/csr_checker.sv */
`timescale 1ns/100ps

`include "csr_consts.svh"

module csr_checker (
	input  logic               clk,
	input  logic               reset_i,
	input  int                 test_id_i,
	input  logic               valid_i,
	input  csr_pkg::funct3_t   funct3_i,
	input  csr_pkg::csr_addr_t csr_addr_i,
	input  csr_pkg::xlen_t     rs1_data_i,
	input  csr_pkg::xlen_t     imm_i,
	input  csr_pkg::xlen_t     pc_i,
	input  logic               irq_i,
	input  csr_pkg::xlen_t     rd_data_i,
	input  logic               redirect_i,
	input  csr_pkg::xlen_t     redirect_pc_i,
	input  logic               stall_i,
	output int                 check_count_o,
	output int                 error_count_o
);

	import csr_pkg::*;
	import trap_pkg::*;

	// model of the six CSRs
	xlen_t  m_status;
	xlen_t  m_ie;
	xlen_t  m_tvec;
	xlen_t  m_scratch;
	xlen_t  m_epc;
	cause_t m_cause;

	logic   sleeping = 1'b0;
	logic   exp_redirect = 1'b0;
	logic   take_redirect = 1'b0;
	xlen_t  exp_pc = '0;
	int     cur_test = 0;
	int     n_checks = 0;
	int     n_errors = 0;
	int     t_checks = 0;
	int     t_errors = 0;

	assign check_count_o = n_checks;
	assign error_count_o = n_errors;

	function automatic string test_name(input int id);
		case (id)
			1: return "rw_random";
			2: return "unmapped";
			3: return "ecall_ebreak";
			4: return "mret";
			5: return "wfi";
			6: return "irq";
			default: return "idle";
		endcase
	endfunction

	function automatic xlen_t model_read(input csr_addr_t addr);
		case (addr)
			`CSR_MSTATUS:  return m_status;
			`CSR_MIE:      return m_ie;
			`CSR_MTVEC:    return m_tvec;
			`CSR_MSCRATCH: return m_scratch;
			`CSR_MEPC:     return m_epc;
			`CSR_MCAUSE:   return m_cause;
			default:       return '0;
		endcase
	endfunction

	// only the implemented fields keep what is written
	task automatic model_write(input csr_addr_t addr, input xlen_t value);
		case (addr)
			`CSR_MSTATUS: begin
				m_status = '0;
				m_status[`MSTATUS_MIE]  = value[`MSTATUS_MIE];
				m_status[`MSTATUS_MPIE] = value[`MSTATUS_MPIE];
			end
			`CSR_MIE: begin
				m_ie = '0;
				m_ie[`MIE_MEIE] = value[`MIE_MEIE];
			end
			`CSR_MTVEC:    m_tvec = {value[31:2], 2'b00};
			`CSR_MSCRATCH: m_scratch = value;
			`CSR_MEPC:     m_epc = {value[31:2], 2'b00};
			`CSR_MCAUSE:   m_cause = value;
			default: ;
		endcase
	endtask

	task automatic enter_trap(input xlen_t pc, input cause_t cause);
		m_status[`MSTATUS_MPIE] = m_status[`MSTATUS_MIE];
		m_status[`MSTATUS_MIE]  = 1'b0;
		m_epc = {pc[31:2], 2'b00};
		m_cause = cause;
		exp_pc = m_tvec;
		take_redirect = 1'b1;
	endtask

	task automatic leave_trap;
		exp_pc = m_epc;
		m_status[`MSTATUS_MIE]  = m_status[`MSTATUS_MPIE];
		m_status[`MSTATUS_MPIE] = 1'b1;
		take_redirect = 1'b1;
	endtask

	task automatic check_value(input string what, input xlen_t exp, input xlen_t act);
		n_checks++;
		t_checks++;
		if (exp !== act) begin
			n_errors++;
			t_errors++;
			$display("** Error %s %s: expected %h, actual %h",
				test_name(cur_test), what, exp, act);
		end
	endtask

	// inputs and outputs seen here are the values of the cycle that ends at this edge
	always @(posedge clk) begin : step
		xlen_t old;
		if (test_id_i != cur_test) begin
			if (cur_test != 0) begin
				$display("test %-12s done: %0d checks, %0d errors",
					test_name(cur_test), t_checks, t_errors);
			end
			cur_test = test_id_i;
			t_checks = 0;
			t_errors = 0;
		end
		if (reset_i) begin
			m_status = '0;
			m_ie = '0;
			m_tvec = '0;
			m_scratch = '0;
			m_epc = '0;
			m_cause = '0;
			sleeping = 1'b0;
			exp_redirect = 1'b0;
		end else begin
			check_value("redirect_o", xlen_t'(exp_redirect), xlen_t'(redirect_i));
			if (exp_redirect) begin
				check_value("redirect_pc_o", exp_pc, redirect_pc_i);
			end
			check_value("stall_o", xlen_t'(sleeping), xlen_t'(stall_i));
			take_redirect = 1'b0;
			old = model_read(csr_addr_i);
			if (sleeping) begin
				// any irq level wakes, enabled or not
				if (irq_i) begin
					sleeping = 1'b0;
				end
			end else if (valid_i) begin
				check_value("rd_data_o", old, rd_data_i);
				case (funct3_i)
					`F3_CSRRW:  model_write(csr_addr_i, rs1_data_i);
					`F3_CSRRS:  model_write(csr_addr_i, old | rs1_data_i);
					`F3_CSRRC:  model_write(csr_addr_i, old & ~rs1_data_i);
					`F3_CSRRWI: model_write(csr_addr_i, imm_i);
					`F3_CSRRSI: model_write(csr_addr_i, old | imm_i);
					`F3_CSRRCI: model_write(csr_addr_i, old & ~imm_i);
					`F3_PRIV: begin
						case (csr_addr_i)
							`SYS_ECALL:  enter_trap(pc_i, `CAUSE_ECALL_M);
							`SYS_EBREAK: enter_trap(pc_i, `CAUSE_BREAKPOINT);
							`SYS_MRET, `SYS_MRET_ALT0, `SYS_MRET_ALT1: leave_trap();
							`SYS_WFI:    sleeping = 1'b1;
							default: ;
						endcase
					end
					default: ;
				endcase
			end else if (irq_i && m_status[`MSTATUS_MIE] && m_ie[`MIE_MEIE]) begin
				enter_trap(pc_i, `CAUSE_M_EXT_IRQ);
			end
			exp_redirect = take_redirect;
		end
	end

endmodule

/* sim/csr_unit_tb.sv */
`timescale 1ns/100ps

`include "csr_consts.svh"

module csr_unit_tb;

	import csr_pkg::*;

	localparam int        WAIT_LIMIT = 50;
	localparam csr_addr_t UNMAPPED   = 12'h7c0;

	logic      clk;
	logic      reset_i;
	logic      valid_i;
	funct3_t   funct3_i;
	csr_addr_t csr_addr_i;
	xlen_t     rs1_data_i;
	xlen_t     imm_i;
	xlen_t     pc_i;
	logic      irq_i;
	xlen_t     rd_data_o;
	logic      redirect_o;
	xlen_t     redirect_pc_o;
	logic      stall_o;

	int        test_id;
	int        seed;
	int        n_timeouts;
	int        check_count;
	int        error_count;
	xlen_t     pc_next;

	initial clk = 1'b0;
	always #2 clk = ~clk;

	csr_unit csr_unit_i (
		.clk           (clk),
		.reset_i       (reset_i),
		.valid_i       (valid_i),
		.funct3_i      (funct3_i),
		.csr_addr_i    (csr_addr_i),
		.rs1_data_i    (rs1_data_i),
		.imm_i         (imm_i),
		.pc_i          (pc_i),
		.irq_i         (irq_i),
		.rd_data_o     (rd_data_o),
		.redirect_o    (redirect_o),
		.redirect_pc_o (redirect_pc_o),
		.stall_o       (stall_o)
	);

	csr_checker u_checker (
		.clk           (clk),
		.reset_i       (reset_i),
		.test_id_i     (test_id),
		.valid_i       (valid_i),
		.funct3_i      (funct3_i),
		.csr_addr_i    (csr_addr_i),
		.rs1_data_i    (rs1_data_i),
		.imm_i         (imm_i),
		.pc_i          (pc_i),
		.irq_i         (irq_i),
		.rd_data_i     (rd_data_o),
		.redirect_i    (redirect_o),
		.redirect_pc_i (redirect_pc_o),
		.stall_i       (stall_o),
		.check_count_o (check_count),
		.error_count_o (error_count)
	);

	function automatic csr_addr_t pick_csr(input int k);
		case (k)
			0: return `CSR_MSTATUS;
			1: return `CSR_MIE;
			2: return `CSR_MTVEC;
			3: return `CSR_MEPC;
			4: return `CSR_MCAUSE;
			default: return `CSR_MSCRATCH;
		endcase
	endfunction

	function automatic funct3_t pick_op(input int k);
		case (k)
			0: return `F3_CSRRW;
			1: return `F3_CSRRS;
			2: return `F3_CSRRC;
			3: return `F3_CSRRWI;
			4: return `F3_CSRRSI;
			default: return `F3_CSRRCI;
		endcase
	endfunction

	function automatic csr_addr_t mret_code(input int k);
		case (k)
			0: return `SYS_MRET;
			1: return `SYS_MRET_ALT0;
			default: return `SYS_MRET_ALT1;
		endcase
	endfunction

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic xlen_t rand_word();
		return $random(seed);
	endfunction

	// the held instruction is taken at the first edge with stall_o low
	task automatic wait_run;
		int n;
		n = 0;
		@(negedge clk);
		while (stall_o && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (stall_o) begin
			$display("timeout: stall_o still high after %0d cycles", WAIT_LIMIT);
			n_timeouts++;
		end
	endtask

	task automatic wait_stall(input logic level, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (stall_o !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (stall_o !== level) begin
			$display("timeout: %s within %0d cycles", what, WAIT_LIMIT);
			n_timeouts++;
		end
	endtask

	task automatic wait_redirect(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!redirect_o && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!redirect_o) begin
			$display("timeout: no redirect after %s within %0d cycles", what, WAIT_LIMIT);
			n_timeouts++;
		end
	endtask

	task automatic issue(input funct3_t f3, input csr_addr_t addr, input xlen_t rs1,
		input xlen_t imm);
		wait_run();
		@(posedge clk);
		valid_i    <= 1'b1;
		funct3_i   <= f3;
		csr_addr_i <= addr;
		rs1_data_i <= rs1;
		imm_i      <= imm;
		pc_i       <= pc_next;
		pc_next = pc_next + 32'd4;
	endtask

	task automatic idle;
		wait_run();
		@(posedge clk);
		valid_i <= 1'b0;
	endtask

	task automatic read_csr(input csr_addr_t addr);
		issue(`F3_CSRRS, addr, '0, '0);
	endtask

	task automatic write_csr(input csr_addr_t addr, input xlen_t value);
		issue(`F3_CSRRW, addr, value, '0);
	endtask

	task automatic set_irq(input logic level);
		@(posedge clk);
		irq_i <= level;
	endtask

	task automatic begin_test(input int id);
		test_id <= id;
	endtask

	initial begin : main
		int        i;
		csr_addr_t addr;
		seed = 38558;
		n_timeouts = 0;
		pc_next = 32'h0000_1000;
		test_id = 0;
		reset_i = 1'b1;
		valid_i = 1'b0;
		funct3_i = '0;
		csr_addr_i = '0;
		rs1_data_i = '0;
		imm_i = '0;
		pc_i = '0;
		irq_i = 1'b0;
		repeat (8) @(posedge clk);
		reset_i <= 1'b0;

		// random csr ops, each followed by a read of the same register
		begin_test(1);
		for (i = 0; i < 400; i++) begin
			addr = pick_csr(rand_below(6));
			issue(pick_op(rand_below(6)), addr, rand_word(), rand_word() & 32'h1f);
			read_csr(addr);
		end

		idle();
		begin_test(2);
		for (i = 0; i < 20; i++) begin
			issue(pick_op(rand_below(6)), UNMAPPED, rand_word(), rand_word() & 32'h1f);
		end
		for (i = 0; i < 6; i++) begin
			read_csr(pick_csr(i));
		end

		idle();
		begin_test(3);
		write_csr(`CSR_MTVEC, rand_word());
		write_csr(`CSR_MSTATUS, 32'd1 << `MSTATUS_MIE);
		issue(`F3_PRIV, `SYS_ECALL, '0, '0);
		idle();
		wait_redirect("ecall");
		read_csr(`CSR_MEPC);
		read_csr(`CSR_MCAUSE);
		read_csr(`CSR_MSTATUS);
		issue(`F3_PRIV, `SYS_EBREAK, '0, '0);
		idle();
		wait_redirect("ebreak");
		read_csr(`CSR_MEPC);
		read_csr(`CSR_MCAUSE);
		read_csr(`CSR_MSTATUS);

		idle();
		begin_test(4);
		for (i = 0; i < 3; i++) begin
			write_csr(`CSR_MEPC, rand_word());
			write_csr(`CSR_MSTATUS, rand_word());
			issue(`F3_PRIV, mret_code(i), '0, '0);
			idle();
			wait_redirect("mret");
			read_csr(`CSR_MSTATUS);
		end

		// the write after wfi is held until the wake
		idle();
		begin_test(5);
		write_csr(`CSR_MSTATUS, '0);
		write_csr(`CSR_MIE, '0);
		issue(`F3_PRIV, `SYS_WFI, '0, '0);
		write_csr(`CSR_MSCRATCH, rand_word());
		wait_stall(1'b1, "stall_o did not rise after wfi");
		repeat (8) @(posedge clk);
		set_irq(1'b1);
		wait_stall(1'b0, "stall_o did not clear after irq");
		idle();
		set_irq(1'b0);

		idle();
		begin_test(6);
		write_csr(`CSR_MTVEC, rand_word());
		write_csr(`CSR_MIE, 32'd1 << `MIE_MEIE);
		write_csr(`CSR_MSTATUS, 32'd1 << `MSTATUS_MIE);
		idle();
		set_irq(1'b1);
		wait_redirect("irq");
		set_irq(1'b0);
		read_csr(`CSR_MCAUSE);
		read_csr(`CSR_MEPC);
		read_csr(`CSR_MSTATUS);
		// one enable bit clear, no trap expected
		write_csr(`CSR_MIE, '0);
		write_csr(`CSR_MSTATUS, 32'd1 << `MSTATUS_MIE);
		idle();
		set_irq(1'b1);
		repeat (20) @(posedge clk);
		set_irq(1'b0);
		write_csr(`CSR_MIE, 32'd1 << `MIE_MEIE);
		write_csr(`CSR_MSTATUS, '0);
		idle();
		set_irq(1'b1);
		repeat (20) @(posedge clk);
		set_irq(1'b0);

		idle();
		begin_test(0);
		repeat (3) @(posedge clk);
		$display("summary: %0d checks, %0d errors, %0d timeouts",
			check_count, error_count, n_timeouts);
		if (error_count == 0 && n_timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
